/* project.f */
src/dcache_pkg.sv
src/uncached_bypass.sv
src/cache_ctrl.sv
src/tag_store.sv
src/data_store.sv
src/replace_policy.sv
src/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

/* run.sh */
#!/bin/sh
# builds the dcache testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_dcache -f project.f -o sim_dcache
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_dcache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
exit 1

/* sim/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

    logic                 clk;
    logic                 rst;
    dcache_pkg::cpu_req_t p_req;
    logic                 p_strobe;
    logic                 p_ready;
    logic [31:0]          p_din;
    dcache_pkg::mem_req_t m_req;
    logic                 m_strobe;
    logic                 m_ready = 1'b0;
    logic [31:0]          m_dout  = '0;
    int                   errors;
    int                   checks;
    int                   n_directed = 12;
    int                   n_random   = 400;
    logic [31:0]          mem [logic [31:0]];  // backing memory by word address
    logic [3:0]           nibs [6] = '{4'h2, 4'h3, 4'h6, 4'h7, 4'hc, 4'hd};  // cached regions

    dcache_top uut (
        .clk      (clk),
        .rst      (rst),
        .p_req    (p_req),
        .p_strobe (p_strobe),
        .p_ready  (p_ready),
        .p_din    (p_din),
        .m_req    (m_req),
        .m_strobe (m_strobe),
        .m_ready  (m_ready),
        .m_dout   (m_dout)
    );

    dcache_checker chk (
        .clk      (clk),
        .rst      (rst),
        .p_req    (p_req),
        .p_strobe (p_strobe),
        .p_ready  (p_ready),
        .p_din    (p_din),
        .m_req    (m_req),
        .m_strobe (m_strobe),
        .m_ready  (m_ready),
        .m_dout   (m_dout),
        .errors   (errors),
        .checks   (checks)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////
    // memory model
    //////////////////////////////
    function automatic logic [31:0] mem_read(input logic [31:0] a);
        logic [31:0] wa;
        wa = {a[31:2], 2'b00};
        if (mem.exists(wa)) return mem[wa];
        return (wa * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;  // word never written
    endfunction

    always begin
        logic [31:0] word;
        @(posedge clk);
        if (!rst && m_strobe) begin
            repeat ($urandom % 4) @(posedge clk);  // 0 to 3 wait cycles
            @(negedge clk);
            word   = mem_read(m_req.addr);
            m_dout = word;
            if (m_req.rw) begin
                for (int b = 0; b < 4; b++) begin
                    if (m_req.wen[b]) word[8*b +: 8] = m_req.wdata[8*b +: 8];
                end
                mem[{m_req.addr[31:2], 2'b00}] = word;
            end
            m_ready = 1'b1;
            @(negedge clk);
            m_ready = 1'b0;
        end
    end

    //////////////////////////////
    // stimulus
    //////////////////////////////
    task automatic run_access(input logic [31:0] addr, input logic rw, input logic [3:0] wen,
                              input logic [31:0] wdata, input logic [1:0] size);
        p_req.addr  = addr;
        p_req.wdata = wdata;
        p_req.wen   = wen;
        p_req.size  = size;
        p_req.rw    = rw;
        p_strobe    = 1'b1;
        do begin
            @(posedge clk);
        end while (p_ready !== 1'b1);
        @(negedge clk);
        p_strobe = 1'b0;
    endtask

    task automatic random_access();
        logic [31:0] addr;
        logic        rw;
        repeat ($urandom % 2) @(negedge clk);
        rw = 1'($urandom % 2);
        if ($urandom % 5 == 0) begin
            // small uncached window, 8 aliases a and 9 aliases b
            addr = {4'(8 + $urandom % 4), 20'h0, 6'($urandom % 16), 2'b00};
        end else begin
            addr = {nibs[$urandom % 6], 22'h0, 2'b00, 2'($urandom % 4), 2'b00};  // sets 0..3
        end
        run_access(addr, rw, 4'($urandom % 15 + 1), $urandom, 2'($urandom % 3));
    endtask

    initial begin
        void'($urandom(32'h4021));
        rst      = 1'b1;
        p_strobe = 1'b0;
        p_req    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) @(negedge clk);  // idle, memory port stays quiet

        // six tags in set 5 force evictions of dirty lines
        for (int i = 0; i < 6; i++) begin
            run_access({nibs[i], 22'h0, 4'h5, 2'b00}, 1'b1, 4'hf, $urandom, 2'd2);
        end
        for (int i = 0; i < 6; i++) begin
            run_access({nibs[i], 22'h0, 4'h5, 2'b00}, 1'b0, 4'hf, 32'h0, 2'd2);
        end
        for (int i = 0; i < n_random; i++) begin
            random_access();
        end

        repeat (3) @(negedge clk);
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // worst access is a write-back and a refill of 5 cycles each plus idle, 16 cycles
    initial begin
        #((n_directed + n_random) * 16 * 40 + 2000);
        $display("timeout: accesses did not complete in time");
        $display("Errors found");
        $finish;
    end

endmodule

/* sim/dcache_checker.sv */
`timescale 1ns/1ps

module dcache_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  dcache_pkg::cpu_req_t p_req,
    input  logic                 p_strobe,
    input  logic                 p_ready,
    input  logic [31:0]          p_din,
    input  dcache_pkg::mem_req_t m_req,
    input  logic                 m_strobe,
    input  logic                 m_ready,
    input  logic [31:0]          m_dout,
    output int                   errors,
    output int                   checks
);

    // expected outcome of one cached access
    typedef struct packed {
        logic        hit;
        logic [1:0]  way;      // hit way or victim way on a miss
        logic        wb;
        logic [31:0] wb_addr;
    } expect_t;

    logic        mv [4][16];   // reference valid, dirty, tag and age
    logic        md [4][16];
    logic [25:0] mt [4][16];
    logic [3:0]  ma [4][16];
    logic [31:0] shadow [logic [31:0]];  // word the processor should read back

    expect_t exp_acc;
    logic    active;
    logic    acc_unc;
    int      ops_seen;
    int      ops_needed;

    function automatic logic [31:0] fill_pattern(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] shadow_read(input logic [31:0] a);
        return shadow.exists(a) ? shadow[a] : fill_pattern(a);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  lanes);
        logic [31:0] w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (lanes[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    // address that memory sees for an uncached region
    function automatic logic [31:0] remap_region(input logic [31:0] a);
        logic [31:0] r;
        r = a;
        case (a[31:28])
            4'h8, 4'ha: r[31:28] = 4'h0;
            4'h9, 4'hb: r[31:28] = 4'h1;
            default:    r[31:28] = a[31:28];
        endcase
        return r;
    endfunction

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic expect_t predict_access(input logic [31:0] a);
        expect_t    e;
        logic [3:0] s;
        int         best;
        s    = a[5:2];
        e    = '0;
        best = -1;
        for (int w = 0; w < 4; w++) begin
            if (mv[w][s] && mt[w][s] == a[31:6]) begin
                e.hit = 1'b1;
                e.way = 2'(w);
            end
        end
        if (!e.hit) begin
            for (int w = 3; w >= 0; w--) begin
                if (!mv[w][s]) best = w;  // lowest empty way
            end
            if (best < 0) begin
                best = 0;
                for (int w = 1; w < 4; w++) begin
                    if (ma[w][s] > ma[best][s]) best = w;
                end
            end
            e.way     = 2'(best);
            e.wb      = mv[best][s] & md[best][s];
            e.wb_addr = {mt[best][s], s, 2'b00};
        end
        return e;
    endfunction

    task automatic touch_ages(input logic [3:0] s, input logic [1:0] w);
        for (int i = 0; i < 4; i++) begin
            if (i == int'(w)) ma[i][s] = 4'd0;
            else if (ma[i][s] != 4'hf) ma[i][s] = ma[i][s] + 4'd1;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("at %0t ns: %s", $time, what);
    endtask

    //////////////////////////////
    // comparisons
    //////////////////////////////
    always @(posedge clk) begin
        logic [31:0] a;
        logic [31:0] wa;
        logic [31:0] phys;
        logic [3:0]  s;
        a    = p_req.addr;
        wa   = {a[31:2], 2'b00};
        phys = remap_region(a);
        s    = a[5:2];
        if (rst) begin
            for (int w = 0; w < 4; w++) begin
                for (int si = 0; si < 16; si++) begin
                    mv[w][si] = 1'b0;
                    md[w][si] = 1'b0;
                    mt[w][si] = '0;
                    ma[w][si] = '0;
                end
            end
            active = 1'b0;
            errors = 0;
            checks = 0;
        end else if (!p_strobe) begin
            if (p_ready) report_problem("p_ready high with no access pending");
            if (m_strobe) report_problem("memory request issued with no access pending");
        end else begin
            if (!active) begin
                active   = 1'b1;
                ops_seen = 0;
                acc_unc  = (a[31:28] >= 4'h8) && (a[31:28] <= 4'hb);  // regions 8 to b
                exp_acc  = predict_access(a);
            end
            ops_needed = exp_acc.hit ? 0 : (exp_acc.wb ? 2 : 1);

            if (m_strobe && m_ready) begin
                ops_seen++;
                if (acc_unc) begin
                    compare_word("m_req.addr", phys, m_req.addr);
                    compare_word("m_req.wdata", p_req.wdata, m_req.wdata);
                    compare_word("m_req.wen", 32'(p_req.wen), 32'(m_req.wen));
                    compare_word("m_req.size", 32'(p_req.size), 32'(m_req.size));
                    compare_word("m_req.rw", 32'(p_req.rw), 32'(m_req.rw));
                end else if (ops_seen > ops_needed) begin
                    report_problem("extra memory request during a cached access");
                end else begin
                    compare_word("m_req.wen", 32'hf, 32'(m_req.wen));
                    compare_word("m_req.size", 32'd2, 32'(m_req.size));
                    if (exp_acc.wb && ops_seen == 1) begin
                        compare_word("m_req.rw", 32'd1, 32'(m_req.rw));
                        compare_word("m_req.addr", exp_acc.wb_addr, m_req.addr);
                        compare_word("m_req.wdata", shadow_read(exp_acc.wb_addr), m_req.wdata);
                    end else begin
                        compare_word("m_req.rw", 32'd0, 32'(m_req.rw));
                        compare_word("m_req.addr", wa, m_req.addr);
                    end
                end
            end

            if (p_ready) begin
                if (acc_unc) begin
                    if (ops_seen != 1) begin
                        report_problem("uncached access did not make exactly one memory transfer");
                    end
                    if (p_req.rw) begin
                        shadow[{phys[31:2], 2'b00}] = merge_bytes(
                            shadow_read({phys[31:2], 2'b00}), p_req.wdata, p_req.wen);
                    end else begin
                        compare_word("p_din", m_dout, p_din);
                        compare_word("p_din", shadow_read({phys[31:2], 2'b00}), p_din);
                    end
                end else begin
                    if (ops_seen < ops_needed) begin
                        report_problem("cached access finished with a memory transfer missing");
                    end
                    if (!exp_acc.hit) begin
                        mv[exp_acc.way][s] = 1'b1;  // refill
                        md[exp_acc.way][s] = 1'b0;
                        mt[exp_acc.way][s] = a[31:6];
                        touch_ages(s, exp_acc.way);
                    end
                    if (p_req.rw) begin
                        shadow[wa] = merge_bytes(shadow_read(wa), p_req.wdata, p_req.wen);
                        md[exp_acc.way][s] = 1'b1;
                        touch_ages(s, exp_acc.way);
                    end else begin
                        compare_word("p_din", shadow_read(wa), p_din);
                    end
                end
                active = 1'b0;
            end
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  dcache_pkg::cpu_req_t          p_req,
    input  logic                          p_strobe,
    output logic                          p_ready,
    output logic [dcache_pkg::addr_w-1:0] p_din,
    output dcache_pkg::mem_req_t          m_req,
    output logic                          m_strobe,
    input  logic                          m_ready,
    input  logic [dcache_pkg::addr_w-1:0] m_dout
);

    logic                            uncached;
    dcache_pkg::mem_req_t            ctrl_mem;
    logic                            ctrl_strobe;
    logic                            byp_ready;
    logic [dcache_pkg::addr_w-1:0]   byp_din;
    logic                            hit;
    dcache_pkg::way_t                hit_way;
    logic                            victim_dirty;
    logic [dcache_pkg::tag_bits-1:0] victim_tag;
    dcache_pkg::way_t                victim_way;
    logic [dcache_pkg::addr_w-1:0]   victim_word;
    logic [dcache_pkg::addr_w-1:0]   hit_word;
    logic                            fill_en;
    logic                            write_en;
    logic                            touch;
    dcache_pkg::way_t                touch_way;
    logic [dcache_pkg::way_cnt-1:0]  valid_mask;

    uncached_bypass u_bypass (
        .p_req       (p_req),
        .p_strobe    (p_strobe),
        .ctrl_mem    (ctrl_mem),
        .ctrl_strobe (ctrl_strobe),
        .m_ready     (m_ready),
        .m_dout      (m_dout),
        .uncached    (uncached),
        .m_req       (m_req),
        .m_strobe    (m_strobe),
        .byp_ready   (byp_ready),
        .byp_din     (byp_din)
    );

    cache_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .p_req        (p_req),
        .p_strobe     (p_strobe),
        .uncached     (uncached),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .victim_way   (victim_way),
        .victim_word  (victim_word),
        .m_ready      (m_ready),
        .byp_ready    (byp_ready),
        .byp_din      (byp_din),
        .hit_word     (hit_word),
        .ctrl_mem     (ctrl_mem),
        .ctrl_strobe  (ctrl_strobe),
        .fill_en      (fill_en),
        .write_en     (write_en),
        .touch        (touch),
        .touch_way    (touch_way),
        .p_ready      (p_ready),
        .p_din        (p_din)
    );

    tag_store u_tags (
        .clk          (clk),
        .rst          (rst),
        .addr         (p_req.addr),
        .fill_en      (fill_en),
        .write_en     (write_en),
        .victim_way   (victim_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag),
        .valid_mask   (valid_mask)
    );

    data_store u_data (
        .clk         (clk),
        .addr        (p_req.addr),
        .fill_en     (fill_en),
        .write_en    (write_en),
        .wen         (p_req.wen),
        .wdata       (p_req.wdata),
        .m_dout      (m_dout),
        .hit_way     (hit_way),
        .victim_way  (victim_way),
        .hit_word    (hit_word),
        .victim_word (victim_word)
    );

    replace_policy u_repl (
        .clk        (clk),
        .rst        (rst),
        .index      (p_req.addr.cache.index),
        .touch      (touch),
        .touch_way  (touch_way),
        .valid_mask (valid_mask),
        .victim_way (victim_way)
    );

endmodule

/* src/replace_policy.sv */
`timescale 1ns/1ps

module replace_policy (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [dcache_pkg::set_bits-1:0] index,
    input  logic                            touch,
    input  dcache_pkg::way_t                touch_way,
    input  logic [dcache_pkg::way_cnt-1:0]  valid_mask,
    output dcache_pkg::way_t                victim_way
);

    logic [dcache_pkg::age_bits-1:0] ages [dcache_pkg::way_cnt][dcache_pkg::set_cnt];
    logic [dcache_pkg::age_bits-1:0] best_age;
    dcache_pkg::way_t                oldest;
    dcache_pkg::way_t                free_way;
    logic                            any_free;

    //////////////////////////////
    // age update
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::way_cnt; w++) begin
                for (int s = 0; s < dcache_pkg::set_cnt; s++) begin
                    ages[w][s] <= '0;
                end
            end
        end else if (touch) begin
            for (int w = 0; w < dcache_pkg::way_cnt; w++) begin
                if (dcache_pkg::way_t'(w) == touch_way) begin
                    ages[w][index] <= '0;
                end else if (ages[w][index] != dcache_pkg::age_max) begin
                    ages[w][index] <= ages[w][index] + 1'b1;  // saturating
                end
            end
        end
    end

    //////////////////////////////
    // victim choice
    //////////////////////////////
    always_comb begin
        oldest   = '0;
        best_age = ages[0][index];
        for (int w = 1; w < dcache_pkg::way_cnt; w++) begin
            if (ages[w][index] > best_age) begin  // strict, lower way keeps ties
                best_age = ages[w][index];
                oldest   = dcache_pkg::way_t'(w);
            end
        end

        // an empty way always wins, lowest first
        any_free = 1'b0;
        free_way = '0;
        for (int w = dcache_pkg::way_cnt - 1; w >= 0; w--) begin
            if (!valid_mask[w]) begin
                any_free = 1'b1;
                free_way = dcache_pkg::way_t'(w);
            end
        end

        victim_way = any_free ? free_way : oldest;
    end

endmodule

/* src/data_store.sv */
`timescale 1ns/1ps

module data_store (
    input  logic                              clk,
    input  dcache_pkg::addr_u                 addr,
    input  logic                              fill_en,
    input  logic                              write_en,
    input  logic [dcache_pkg::addr_w/8-1:0]   wen,
    input  logic [dcache_pkg::addr_w-1:0]     wdata,
    input  logic [dcache_pkg::addr_w-1:0]     m_dout,
    input  dcache_pkg::way_t                  hit_way,
    input  dcache_pkg::way_t                  victim_way,
    output logic [dcache_pkg::addr_w-1:0]     hit_word,
    output logic [dcache_pkg::addr_w-1:0]     victim_word
);

    logic [dcache_pkg::addr_w-1:0]   words [dcache_pkg::way_cnt][dcache_pkg::set_cnt];
    logic [dcache_pkg::addr_w-1:0]   merged;  // hit word with new bytes laid over
    logic [dcache_pkg::set_bits-1:0] idx;

    assign idx = addr.cache.index;

    // two read ports, hit way and victim way
    assign hit_word    = words[hit_way][idx];
    assign victim_word = words[victim_way][idx];

    always_comb begin
        merged = hit_word;
        for (int b = 0; b < dcache_pkg::addr_w / 8; b++) begin
            if (wen[b]) begin
                merged[8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            words[victim_way][idx] <= m_dout;  // whole word from memory
        end else if (write_en) begin
            words[hit_way][idx] <= merged;
        end
    end

endmodule

/* src/tag_store.sv */
`timescale 1ns/1ps

module tag_store (
    input  logic                            clk,
    input  logic                            rst,
    input  dcache_pkg::addr_u               addr,
    input  logic                            fill_en,
    input  logic                            write_en,
    input  dcache_pkg::way_t                victim_way,
    output logic                            hit,
    output dcache_pkg::way_t                hit_way,
    output logic                            victim_dirty,
    output logic [dcache_pkg::tag_bits-1:0] victim_tag,
    output logic [dcache_pkg::way_cnt-1:0]  valid_mask
);

    logic [dcache_pkg::tag_bits-1:0] tags  [dcache_pkg::way_cnt][dcache_pkg::set_cnt];
    logic                            valid [dcache_pkg::way_cnt][dcache_pkg::set_cnt];
    logic                            dirty [dcache_pkg::way_cnt][dcache_pkg::set_cnt];
    logic [dcache_pkg::set_bits-1:0] idx;

    assign idx = addr.cache.index;

    // all ways compared at once
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < dcache_pkg::way_cnt; w++) begin
            valid_mask[w] = valid[w][idx];
            if (valid[w][idx] && (tags[w][idx] == addr.cache.tag)) begin
                hit     = 1'b1;
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign victim_dirty = valid[victim_way][idx] & dirty[victim_way][idx];
    assign victim_tag   = tags[victim_way][idx];

    //////////////////////////////
    // line status
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < dcache_pkg::way_cnt; w++) begin
                for (int s = 0; s < dcache_pkg::set_cnt; s++) begin
                    valid[w][s] <= 1'b0;
                    dirty[w][s] <= 1'b0;
                end
            end
        end else if (fill_en) begin
            valid[victim_way][idx] <= 1'b1;
            dirty[victim_way][idx] <= 1'b0;  // fresh copy of memory
        end else if (write_en) begin
            dirty[hit_way][idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tags[victim_way][idx] <= addr.cache.tag;
        end
    end

endmodule

/* src/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                            clk,
    input  logic                            rst,
    input  dcache_pkg::cpu_req_t            p_req,
    input  logic                            p_strobe,
    input  logic                            uncached,
    input  logic                            hit,
    input  dcache_pkg::way_t                hit_way,
    input  logic                            victim_dirty,
    input  logic [dcache_pkg::tag_bits-1:0] victim_tag,
    input  dcache_pkg::way_t                victim_way,
    input  logic [dcache_pkg::addr_w-1:0]   victim_word,
    input  logic                            m_ready,
    input  logic                            byp_ready,
    input  logic [dcache_pkg::addr_w-1:0]   byp_din,
    input  logic [dcache_pkg::addr_w-1:0]   hit_word,
    output dcache_pkg::mem_req_t            ctrl_mem,
    output logic                            ctrl_strobe,
    output logic                            fill_en,
    output logic                            write_en,
    output logic                            touch,
    output dcache_pkg::way_t                touch_way,
    output logic                            p_ready,
    output logic [dcache_pkg::addr_w-1:0]   p_din
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t state_nxt;
    dcache_pkg::addr_u       line_addr;  // word address for cache traffic
    logic                    cached_acc;
    logic                    hit_done;

    assign cached_acc = p_strobe & ~uncached;
    assign hit_done   = cached_acc & hit & (state == dcache_pkg::lookup);

    //////////////////////////////
    // miss fsm
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::lookup;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            dcache_pkg::lookup: begin
                if (cached_acc && !hit) begin
                    // dirty victim goes out before the new word comes in
                    state_nxt = victim_dirty ? dcache_pkg::write_back : dcache_pkg::refill;
                end
            end
            dcache_pkg::write_back: begin
                if (m_ready) begin
                    state_nxt = dcache_pkg::refill;
                end
            end
            dcache_pkg::refill: begin
                if (m_ready) begin
                    state_nxt = dcache_pkg::lookup;  // retried as a hit next cycle
                end
            end
            default: state_nxt = dcache_pkg::lookup;
        endcase
    end

    //////////////////////////////
    // memory requests
    //////////////////////////////
    always_comb begin
        line_addr              = p_req.addr;
        line_addr.cache.offset = '0;
        if (state == dcache_pkg::write_back) begin
            line_addr.cache.tag = victim_tag;  // victim lives at the same index
        end
    end

    always_comb begin
        ctrl_mem.addr  = line_addr;
        ctrl_mem.wdata = victim_word;  // ignored by memory on refill
        ctrl_mem.wen   = '1;
        ctrl_mem.size  = 2'd2;
        ctrl_mem.rw    = (state == dcache_pkg::write_back);
    end

    assign ctrl_strobe = (state != dcache_pkg::lookup);

    // store strobes
    assign fill_en   = (state == dcache_pkg::refill) & m_ready;
    assign write_en  = hit_done & p_req.rw;
    assign touch     = fill_en | write_en;
    assign touch_way = fill_en ? victim_way : hit_way;

    // cpu side
    assign p_ready = uncached ? byp_ready : hit_done;
    assign p_din   = uncached ? byp_din : hit_word;

endmodule

/* src/uncached_bypass.sv */
`timescale 1ns/1ps

module uncached_bypass (
    input  dcache_pkg::cpu_req_t          p_req,
    input  logic                          p_strobe,
    input  dcache_pkg::mem_req_t          ctrl_mem,
    input  logic                          ctrl_strobe,
    input  logic                          m_ready,
    input  logic [dcache_pkg::addr_w-1:0] m_dout,
    output logic                          uncached,
    output dcache_pkg::mem_req_t          m_req,
    output logic                          m_strobe,
    output logic                          byp_ready,
    output logic [dcache_pkg::addr_w-1:0] byp_din
);

    dcache_pkg::addr_u phys;  // address after remap

    // regions 8, 9, a and b share the top bits 2'b10
    assign uncached = (p_req.addr.rgn.nibble[3:2] == 2'b10);

    always_comb begin
        phys            = p_req.addr;
        phys.rgn.nibble = {3'b000, p_req.addr.rgn.nibble[0]};  // 8/a -> 0, 9/b -> 1
    end

    //////////////////////////////
    // memory port steering
    //////////////////////////////
    always_comb begin
        if (uncached) begin
            m_req.addr  = phys;
            m_req.wdata = p_req.wdata;
            m_req.wen   = p_req.wen;
            m_req.size  = p_req.size;
            m_req.rw    = p_req.rw;
        end else begin
            m_req = ctrl_mem;
        end
    end

    assign m_strobe  = uncached ? p_strobe : ctrl_strobe;
    assign byp_ready = uncached & p_strobe & m_ready;  // memory latency seen by cpu
    assign byp_din   = byp_ready ? m_dout : '0;

endmodule

/* src/dcache_pkg.sv */
package dcache_pkg;

    //////////////////////////////
    // geometry
    //////////////////////////////
    localparam int addr_w   = 32;
    localparam int way_cnt  = 4;
    localparam int set_bits = 4;
    localparam int set_cnt  = 1 << set_bits;
    localparam int off_bits = 2;
    localparam int tag_bits = addr_w - set_bits - off_bits;  // 26
    localparam int rgn_bits = 4;                              // top address nibble
    localparam int age_bits = 4;
    localparam logic [age_bits-1:0] age_max = '1;            // ages saturate here

    typedef logic [1:0] way_t;

    //////////////////////////////
    // address views
    //////////////////////////////
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] index;
        logic [off_bits-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic [rgn_bits-1:0]        nibble;
        logic [addr_w-rgn_bits-1:0] rest;
    } region_addr_t;

    // one address word, read as cache fields or as a region
    typedef union packed {
        cache_addr_t  cache;
        region_addr_t rgn;
    } addr_u;

    //////////////////////////////
    // requests
    //////////////////////////////
    typedef struct packed {
        addr_u                 addr;
        logic [addr_w-1:0]     wdata;
        logic [addr_w/8-1:0]   wen;   // byte lanes
        logic [1:0]            size;  // 0 byte, 1 half, 2 word
        logic                  rw;    // 1 = write
    } cpu_req_t;

    typedef struct packed {
        logic [addr_w-1:0]     addr;
        logic [addr_w-1:0]     wdata;
        logic [addr_w/8-1:0]   wen;
        logic [1:0]            size;
        logic                  rw;
    } mem_req_t;

    typedef enum logic [1:0] {
        lookup,
        write_back,
        refill
    } ctrl_state_t;

endpackage
